// ==== soc_pkg.sv ====
/* Shared widths, region map and response codes for the SoC fabric.
   Imported by every fabric module. */
package soc_pkg;

   typedef logic [63:0] addr_t;
   typedef logic [63:0] data_t;
   typedef logic [7:0]  strb_t;
   typedef logic [1:0]  resp_t;

   localparam resp_t RESP_OKAY   = 2'd0;
   localparam resp_t RESP_SLVERR = 2'd2;
   localparam resp_t RESP_DECERR = 2'd3;

   typedef enum logic [2:0] {
      REG_ROM    = 3'd0,
      REG_APB    = 3'd1,
      REG_CLINT  = 3'd2,
      REG_SLM    = 3'd3,
      REG_SLMDDR = 3'd4,
      REG_DRAM   = 3'd5
   } region_e;

   localparam int NUM_REGIONS   = 6;
   // APB has no memory port
   localparam int NUM_MEM_PORTS = 5;

   typedef logic [2:0]  mem_idx_t;
   typedef logic [31:0] apb_addr_t;
   typedef logic [31:0] apb_data_t;

   // --------------------------------------------------
   // Default address map
   localparam addr_t ROM_BASE    = 64'h0000_0000_0001_0000;
   localparam addr_t ROM_LEN     = 64'h0000_0000_0001_0000;
   localparam addr_t APB_BASE    = 64'h0000_0000_6000_0000;
   localparam addr_t APB_LEN     = 64'h0000_0000_1000_0000;
   localparam addr_t CLINT_BASE  = 64'h0000_0000_0200_0000;
   localparam addr_t CLINT_LEN   = 64'h0000_0000_000C_0000;
   localparam addr_t SLM_BASE    = 64'h0000_0000_0400_0000;
   localparam addr_t SLM_LEN     = 64'h0000_0000_0400_0000;
   localparam addr_t SLMDDR_BASE = 64'h0000_0000_C000_0000;
   localparam addr_t SLMDDR_LEN  = 64'h0000_0000_4000_0000;
   localparam addr_t DRAM_BASE   = 64'h0000_0000_8000_0000;
   localparam addr_t DRAM_LEN    = 64'h0000_0000_2000_0000;

endpackage

// ==== addr_decode.sv ====
`timescale 1ns/1ps
/* Address decoder: maps a request address onto one of the six regions.
   Purely combinational, hit_o low means no region claims the address. */
module addr_decode
   import soc_pkg::*;
#(
   parameter addr_t ROM_BASE_ADDR    = ROM_BASE,
   parameter addr_t ROM_LENGTH       = ROM_LEN,
   parameter addr_t APB_BASE_ADDR    = APB_BASE,
   parameter addr_t APB_LENGTH       = APB_LEN,
   parameter addr_t CLINT_BASE_ADDR  = CLINT_BASE,
   parameter addr_t CLINT_LENGTH     = CLINT_LEN,
   parameter addr_t SLM_BASE_ADDR    = SLM_BASE,
   parameter addr_t SLM_LENGTH       = SLM_LEN,
   parameter addr_t SLMDDR_BASE_ADDR = SLMDDR_BASE,
   parameter addr_t SLMDDR_LENGTH    = SLMDDR_LEN,
   parameter addr_t DRAM_BASE_ADDR   = DRAM_BASE,
   parameter addr_t DRAM_LENGTH      = DRAM_LEN
) (
   input  addr_t   addr_i,
   output region_e region_o,
   output logic    hit_o
);

   // Ordered by region index
   localparam addr_t BASES [NUM_REGIONS] = '{ROM_BASE_ADDR, APB_BASE_ADDR, CLINT_BASE_ADDR,
                                             SLM_BASE_ADDR, SLMDDR_BASE_ADDR, DRAM_BASE_ADDR};
   localparam addr_t LENS [NUM_REGIONS]  = '{ROM_LENGTH, APB_LENGTH, CLINT_LENGTH,
                                             SLM_LENGTH, SLMDDR_LENGTH, DRAM_LENGTH};

   logic [NUM_REGIONS-1:0] match;

   // Offset from base wraps when below it, so one compare covers both bounds
   always_comb begin
      for (int i = 0; i < NUM_REGIONS; i++) begin
         match[i] = (addr_i - BASES[i]) < LENS[i];
      end
   end

   always_comb begin
      region_o = REG_ROM;
      for (int i = NUM_REGIONS - 1; i >= 0; i--) begin
         if (match[i]) begin
            region_o = region_e'(i);
         end
      end
   end

   assign hit_o = |match;

   // Overlapping windows in the top-level map
   always_comb begin
      if (!$isunknown(addr_i)) begin
         a_single_window : assert final ($onehot0(match))
            else $error("addr_decode: address %h in windows %b", addr_i, match);
      end
   end

endmodule

// ==== req_router.sv ====
`timescale 1ns/1ps
/* Request router for one master with one transfer in flight.
   Decodes the address, forwards to a memory port or the APB bridge, returns the response. */
module req_router
   import soc_pkg::*;
#(
   parameter addr_t ROM_BASE_ADDR    = ROM_BASE,
   parameter addr_t ROM_LENGTH       = ROM_LEN,
   parameter addr_t APB_BASE_ADDR    = APB_BASE,
   parameter addr_t APB_LENGTH       = APB_LEN,
   parameter addr_t CLINT_BASE_ADDR  = CLINT_BASE,
   parameter addr_t CLINT_LENGTH     = CLINT_LEN,
   parameter addr_t SLM_BASE_ADDR    = SLM_BASE,
   parameter addr_t SLM_LENGTH       = SLM_LEN,
   parameter addr_t SLMDDR_BASE_ADDR = SLMDDR_BASE,
   parameter addr_t SLMDDR_LENGTH    = SLMDDR_LEN,
   parameter addr_t DRAM_BASE_ADDR   = DRAM_BASE,
   parameter addr_t DRAM_LENGTH      = DRAM_LEN
) (
   input  logic                      clk,
   input  logic                      rst_n_i,
   // Master request
   input  logic                      req_valid_i,
   output logic                      req_ready_o,
   input  logic                      req_write_i,
   input  addr_t                     req_addr_i,
   input  data_t                     req_wdata_i,
   input  strb_t                     req_strb_i,
   // Master response
   output logic                      rsp_valid_o,
   input  logic                      rsp_ready_i,
   output data_t                     rsp_rdata_o,
   output resp_t                     rsp_resp_o,
   // Memory ports, shared fields are also seen by the bridge
   output addr_t                     mem_addr_o,
   output logic                      mem_write_o,
   output data_t                     mem_wdata_o,
   output strb_t                     mem_strb_o,
   output logic [NUM_MEM_PORTS-1:0]  mem_req_valid_o,
   input  logic [NUM_MEM_PORTS-1:0]  mem_req_ready_i,
   input  logic [NUM_MEM_PORTS-1:0]  mem_rsp_valid_i,
   input  data_t [NUM_MEM_PORTS-1:0] mem_rsp_rdata_i,
   input  logic [NUM_MEM_PORTS-1:0]  mem_rsp_err_i,
   // APB bridge
   output logic                      br_req_valid_o,
   input  logic                      br_req_ready_i,
   input  logic                      br_rsp_valid_i,
   input  data_t                     br_rsp_rdata_i,
   input  resp_t                     br_rsp_resp_i
);

   typedef enum logic [1:0] {ST_IDLE, ST_FWD, ST_WAIT, ST_RESP} state_e;

   localparam logic [NUM_MEM_PORTS-1:0] PORT_ONE = 1;

   state_e                   state_q;
   region_e                  dec_region;
   logic                     dec_hit;
   region_e                  region_q;
   addr_t                    addr_q;
   logic                     write_q;
   data_t                    wdata_q;
   strb_t                    strb_q;
   data_t                    rdata_q;
   resp_t                    resp_q;
   logic                     to_apb;
   mem_idx_t                 port_idx;
   logic [NUM_MEM_PORTS-1:0] port_sel;
   logic                     fwd_valid;
   logic                     fwd_ready;
   logic                     slv_rsp_valid;
   data_t                    slv_rsp_rdata;
   resp_t                    slv_rsp_resp;

   function automatic mem_idx_t port_of(region_e r);
      case (r)
         REG_ROM:    return mem_idx_t'(0);
         REG_CLINT:  return mem_idx_t'(1);
         REG_SLM:    return mem_idx_t'(2);
         REG_SLMDDR: return mem_idx_t'(3);
         default:    return mem_idx_t'(4);
      endcase
   endfunction

   addr_decode #(
      .ROM_BASE_ADDR    (ROM_BASE_ADDR),
      .ROM_LENGTH       (ROM_LENGTH),
      .APB_BASE_ADDR    (APB_BASE_ADDR),
      .APB_LENGTH       (APB_LENGTH),
      .CLINT_BASE_ADDR  (CLINT_BASE_ADDR),
      .CLINT_LENGTH     (CLINT_LENGTH),
      .SLM_BASE_ADDR    (SLM_BASE_ADDR),
      .SLM_LENGTH       (SLM_LENGTH),
      .SLMDDR_BASE_ADDR (SLMDDR_BASE_ADDR),
      .SLMDDR_LENGTH    (SLMDDR_LENGTH),
      .DRAM_BASE_ADDR   (DRAM_BASE_ADDR),
      .DRAM_LENGTH      (DRAM_LENGTH)
   ) u_addr_decode (
      .addr_i   (req_addr_i),
      .region_o (dec_region),
      .hit_o    (dec_hit)
   );

   // --------------------------------------------------
   // Target selection from the held region
   assign to_apb   = (region_q == REG_APB);
   assign port_idx = port_of(region_q);
   assign port_sel = to_apb ? '0 : (PORT_ONE << port_idx);

   assign fwd_ready     = to_apb ? br_req_ready_i : mem_req_ready_i[port_idx];
   assign slv_rsp_valid = to_apb ? br_rsp_valid_i : mem_rsp_valid_i[port_idx];
   assign slv_rsp_rdata = to_apb ? br_rsp_rdata_i : mem_rsp_rdata_i[port_idx];
   assign slv_rsp_resp  = to_apb ? br_rsp_resp_i :
                          (mem_rsp_err_i[port_idx] ? RESP_SLVERR : RESP_OKAY);

   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         state_q <= ST_IDLE;
      end else begin
         case (state_q)
            ST_IDLE: if (req_valid_i) state_q <= dec_hit ? ST_FWD : ST_RESP;
            ST_FWD:  if (fwd_ready) state_q <= ST_WAIT;
            ST_WAIT: if (slv_rsp_valid) state_q <= ST_RESP;
            ST_RESP: if (rsp_ready_i) state_q <= ST_IDLE;
            default: state_q <= ST_IDLE;
         endcase
      end
   end

   // Decode error is the default answer until a slave responds
   always_ff @(posedge clk) begin
      if (state_q == ST_IDLE && req_valid_i) begin
         region_q <= dec_region;
         addr_q   <= req_addr_i;
         write_q  <= req_write_i;
         wdata_q  <= req_wdata_i;
         strb_q   <= req_strb_i;
         rdata_q  <= '0;
         resp_q   <= RESP_DECERR;
      end else if (state_q == ST_WAIT && slv_rsp_valid) begin
         // Write responses carry no data
         rdata_q <= write_q ? '0 : slv_rsp_rdata;
         resp_q  <= slv_rsp_resp;
      end
   end

   assign req_ready_o     = (state_q == ST_IDLE);
   assign rsp_valid_o     = (state_q == ST_RESP);
   assign rsp_rdata_o     = rdata_q;
   assign rsp_resp_o      = resp_q;
   assign mem_addr_o      = addr_q;
   assign mem_write_o     = write_q;
   assign mem_wdata_o     = wdata_q;
   assign mem_strb_o      = strb_q;
   assign mem_req_valid_o = (state_q == ST_FWD) ? port_sel : '0;
   assign br_req_valid_o  = (state_q == ST_FWD) && to_apb;

   assign fwd_valid = (|mem_req_valid_o) || br_req_valid_o;

   // A stalled forward keeps the same target until it is taken
   a_fwd_hold : assert property (@(posedge clk) disable iff (!rst_n_i)
      fwd_valid && !fwd_ready |=> fwd_valid && $stable({mem_req_valid_o, br_req_valid_o}))
      else $error("req_router: forwarded valid dropped before ready");

endmodule

// ==== apb_bridge.sv ====
`timescale 1ns/1ps
/* Bridge from a single 64-bit request to one 32-bit APB transfer.
   Address bit 2 picks the data half; the response is valid for one cycle. */
module apb_bridge
   import soc_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n_i,
   // Request from the router
   input  logic      br_req_valid_i,
   output logic      br_req_ready_o,
   input  logic      br_write_i,
   input  addr_t     br_addr_i,
   input  data_t     br_wdata_i,
   input  strb_t     br_strb_i,
   // Response, always taken by the router
   output logic      br_rsp_valid_o,
   output data_t     br_rsp_rdata_o,
   output resp_t     br_rsp_resp_o,
   // APB
   output logic      psel_o,
   output logic      penable_o,
   output logic      pwrite_o,
   output apb_addr_t paddr_o,
   output apb_data_t pwdata_o,
   input  apb_data_t prdata_i,
   input  logic      pready_i,
   input  logic      pslverr_i
);

   typedef enum logic [1:0] {ST_IDLE, ST_SETUP, ST_ACCESS, ST_RESP} state_e;

   state_e    state_q;
   logic      upper_q;
   apb_addr_t paddr_q;
   logic      pwrite_q;
   apb_data_t pwdata_q;
   apb_data_t prdata_q;
   logic      pslverr_q;
   logic [3:0] lane_strb;
   apb_data_t lane_mask;
   apb_data_t wdata_half;

   // --------------------------------------------------
   // Write lane selection
   assign lane_strb  = br_addr_i[2] ? br_strb_i[7:4] : br_strb_i[3:0];
   assign wdata_half = br_addr_i[2] ? br_wdata_i[63:32] : br_wdata_i[31:0];
   // APB has no strobes, disabled bytes go out as zero
   assign lane_mask  = {{8{lane_strb[3]}}, {8{lane_strb[2]}},
                        {8{lane_strb[1]}}, {8{lane_strb[0]}}};

   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         state_q <= ST_IDLE;
      end else begin
         case (state_q)
            ST_IDLE:   if (br_req_valid_i) state_q <= ST_SETUP;
            ST_SETUP:  state_q <= ST_ACCESS;
            ST_ACCESS: if (pready_i) state_q <= ST_RESP;
            default:   state_q <= ST_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state_q == ST_IDLE && br_req_valid_i) begin
         paddr_q  <= br_addr_i[31:0];
         pwrite_q <= br_write_i;
         pwdata_q <= wdata_half & lane_mask;
         upper_q  <= br_addr_i[2];
      end
      if (state_q == ST_ACCESS && pready_i) begin
         prdata_q  <= prdata_i;
         pslverr_q <= pslverr_i;
      end
   end

   assign br_req_ready_o = (state_q == ST_IDLE);
   assign psel_o         = (state_q == ST_SETUP) || (state_q == ST_ACCESS);
   assign penable_o      = (state_q == ST_ACCESS);
   assign pwrite_o       = pwrite_q;
   assign paddr_o        = paddr_q;
   assign pwdata_o       = pwdata_q;

   // Read word lands in the half it was addressed from
   assign br_rsp_valid_o = (state_q == ST_RESP);
   assign br_rsp_rdata_o = upper_q ? {prdata_q, 32'h0} : {32'h0, prdata_q};
   assign br_rsp_resp_o  = pslverr_q ? RESP_SLVERR : RESP_OKAY;

   // Access phase stays selected with its fields held until pready
   a_access_hold : assert property (@(posedge clk) disable iff (!rst_n_i)
      penable_o && !pready_i |=> psel_o && penable_o && $stable({paddr_o, pwrite_o, pwdata_o}))
      else $error("apb_bridge: access phase dropped or changed before pready");

endmodule

// ==== soc_fabric_top.sv ====
`timescale 1ns/1ps
/* Top level of the SoC fabric: router plus APB bridge behind one master port.
   The address map is set here and handed down to the decoder. */
module soc_fabric_top
   import soc_pkg::*;
#(
   parameter addr_t ROM_BASE_ADDR    = ROM_BASE,
   parameter addr_t ROM_LENGTH       = ROM_LEN,
   parameter addr_t APB_BASE_ADDR    = APB_BASE,
   parameter addr_t APB_LENGTH       = APB_LEN,
   parameter addr_t CLINT_BASE_ADDR  = CLINT_BASE,
   parameter addr_t CLINT_LENGTH     = CLINT_LEN,
   parameter addr_t SLM_BASE_ADDR    = SLM_BASE,
   parameter addr_t SLM_LENGTH       = SLM_LEN,
   parameter addr_t SLMDDR_BASE_ADDR = SLMDDR_BASE,
   parameter addr_t SLMDDR_LENGTH    = SLMDDR_LEN,
   parameter addr_t DRAM_BASE_ADDR   = DRAM_BASE,
   parameter addr_t DRAM_LENGTH      = DRAM_LEN
) (
   input  logic                      clk,
   input  logic                      rst_n_i,
   // Master
   input  logic                      req_valid_i,
   output logic                      req_ready_o,
   input  logic                      req_write_i,
   input  addr_t                     req_addr_i,
   input  data_t                     req_wdata_i,
   input  strb_t                     req_strb_i,
   output logic                      rsp_valid_o,
   input  logic                      rsp_ready_i,
   output data_t                     rsp_rdata_o,
   output resp_t                     rsp_resp_o,
   // Memory ports: ROM, CLINT, SLM, SLMDDR, DRAM
   output addr_t                     mem_addr_o,
   output logic                      mem_write_o,
   output data_t                     mem_wdata_o,
   output strb_t                     mem_strb_o,
   output logic [NUM_MEM_PORTS-1:0]  mem_req_valid_o,
   input  logic [NUM_MEM_PORTS-1:0]  mem_req_ready_i,
   input  logic [NUM_MEM_PORTS-1:0]  mem_rsp_valid_i,
   input  data_t [NUM_MEM_PORTS-1:0] mem_rsp_rdata_i,
   input  logic [NUM_MEM_PORTS-1:0]  mem_rsp_err_i,
   // APB
   output logic                      psel_o,
   output logic                      penable_o,
   output logic                      pwrite_o,
   output apb_addr_t                 paddr_o,
   output apb_data_t                 pwdata_o,
   input  apb_data_t                 prdata_i,
   input  logic                      pready_i,
   input  logic                      pslverr_i
);

   logic  br_req_valid;
   logic  br_req_ready;
   logic  br_rsp_valid;
   data_t br_rsp_rdata;
   resp_t br_rsp_resp;

   req_router #(
      .ROM_BASE_ADDR    (ROM_BASE_ADDR),
      .ROM_LENGTH       (ROM_LENGTH),
      .APB_BASE_ADDR    (APB_BASE_ADDR),
      .APB_LENGTH       (APB_LENGTH),
      .CLINT_BASE_ADDR  (CLINT_BASE_ADDR),
      .CLINT_LENGTH     (CLINT_LENGTH),
      .SLM_BASE_ADDR    (SLM_BASE_ADDR),
      .SLM_LENGTH       (SLM_LENGTH),
      .SLMDDR_BASE_ADDR (SLMDDR_BASE_ADDR),
      .SLMDDR_LENGTH    (SLMDDR_LENGTH),
      .DRAM_BASE_ADDR   (DRAM_BASE_ADDR),
      .DRAM_LENGTH      (DRAM_LENGTH)
   ) u_req_router (
      .clk             (clk),
      .rst_n_i         (rst_n_i),
      .req_valid_i     (req_valid_i),
      .req_ready_o     (req_ready_o),
      .req_write_i     (req_write_i),
      .req_addr_i      (req_addr_i),
      .req_wdata_i     (req_wdata_i),
      .req_strb_i      (req_strb_i),
      .rsp_valid_o     (rsp_valid_o),
      .rsp_ready_i     (rsp_ready_i),
      .rsp_rdata_o     (rsp_rdata_o),
      .rsp_resp_o      (rsp_resp_o),
      .mem_addr_o      (mem_addr_o),
      .mem_write_o     (mem_write_o),
      .mem_wdata_o     (mem_wdata_o),
      .mem_strb_o      (mem_strb_o),
      .mem_req_valid_o (mem_req_valid_o),
      .mem_req_ready_i (mem_req_ready_i),
      .mem_rsp_valid_i (mem_rsp_valid_i),
      .mem_rsp_rdata_i (mem_rsp_rdata_i),
      .mem_rsp_err_i   (mem_rsp_err_i),
      .br_req_valid_o  (br_req_valid),
      .br_req_ready_i  (br_req_ready),
      .br_rsp_valid_i  (br_rsp_valid),
      .br_rsp_rdata_i  (br_rsp_rdata),
      .br_rsp_resp_i   (br_rsp_resp)
   );

   // Bridge reads the same held request fields as the memory ports
   apb_bridge u_apb_bridge (
      .clk            (clk),
      .rst_n_i        (rst_n_i),
      .br_req_valid_i (br_req_valid),
      .br_req_ready_o (br_req_ready),
      .br_write_i     (mem_write_o),
      .br_addr_i      (mem_addr_o),
      .br_wdata_i     (mem_wdata_o),
      .br_strb_i      (mem_strb_o),
      .br_rsp_valid_o (br_rsp_valid),
      .br_rsp_rdata_o (br_rsp_rdata),
      .br_rsp_resp_o  (br_rsp_resp),
      .psel_o         (psel_o),
      .penable_o      (penable_o),
      .pwrite_o       (pwrite_o),
      .paddr_o        (paddr_o),
      .pwdata_o       (pwdata_o),
      .prdata_i       (prdata_i),
      .pready_i       (pready_i),
      .pslverr_i      (pslverr_i)
   );

endmodule

// ==== tb_soc_fabric.sv ====
`timescale 1ns/1ps
/* Testbench for the SoC fabric: memory and APB slave models, a reference model,
   directed and random requests from the master port. Run with verilog.f. */
module tb_soc_fabric;
   import soc_pkg::*;

   localparam int LIMIT    = 200;
   localparam int APB_PORT = 5;

   logic                      clk = 1'b0;
   logic                      rst_n_i;
   logic                      req_valid_i;
   logic                      req_ready_o;
   logic                      req_write_i;
   addr_t                     req_addr_i;
   data_t                     req_wdata_i;
   strb_t                     req_strb_i;
   logic                      rsp_valid_o;
   logic                      rsp_ready_i;
   data_t                     rsp_rdata_o;
   resp_t                     rsp_resp_o;
   addr_t                     mem_addr_o;
   logic                      mem_write_o;
   data_t                     mem_wdata_o;
   strb_t                     mem_strb_o;
   logic [NUM_MEM_PORTS-1:0]  mem_req_valid_o;
   logic [NUM_MEM_PORTS-1:0]  mem_req_ready_i;
   logic [NUM_MEM_PORTS-1:0]  mem_rsp_valid_i;
   data_t [NUM_MEM_PORTS-1:0] mem_rsp_rdata_i;
   logic [NUM_MEM_PORTS-1:0]  mem_rsp_err_i;
   logic                      psel_o;
   logic                      penable_o;
   logic                      pwrite_o;
   apb_addr_t                 paddr_o;
   apb_data_t                 pwdata_o;
   apb_data_t                 prdata_i;
   logic                      pready_i;
   logic                      pslverr_i;

   logic [31:0] lfsr_q = 32'h954b;
   logic        stall = 1'b0;
   int          n_checks = 0;
   int          n_errors = 0;
   int          test_err_start = 0;
   int          rsp_count = 0;
   // APB setup phase seen in the previous cycle
   logic        was_setup = 1'b0;
   // Request in flight, used by the port monitors
   int          cur_port = -1;
   addr_t       cur_addr;
   logic        cur_write;
   data_t       cur_wdata;
   strb_t       cur_strb;
   data_t       exp_rdata_q[$];
   resp_t       exp_resp_q[$];

   soc_fabric_top dut0 (.*);

   always #2 clk = ~clk;

   // --------------------------------------------------
   // Random source
   function automatic logic rand_bit();
      logic b;
      b = lfsr_q[0];
      lfsr_q = lfsr_q >> 1;
      if (b) begin
         lfsr_q = lfsr_q ^ 32'hB4BC_D35C;
      end
      return b;
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         v = {v[30:0], rand_bit()};
      end
      return v;
   endfunction

   // --------------------------------------------------
   // Expected behavior
   function automatic logic in_window(input addr_t a, input addr_t base, input addr_t len);
      return (a >= base) && (a < base + len);
   endfunction

   function automatic void ref_model(input addr_t a, input logic wr, output int port,
                                     output resp_t resp, output data_t rdata);
      logic      err;
      apb_data_t word;
      err  = (a[11:4] == 8'hff);
      port = -1;
      if (in_window(a, ROM_BASE, ROM_LEN)) port = 0;
      if (in_window(a, CLINT_BASE, CLINT_LEN)) port = 1;
      if (in_window(a, SLM_BASE, SLM_LEN)) port = 2;
      if (in_window(a, SLMDDR_BASE, SLMDDR_LEN)) port = 3;
      if (in_window(a, DRAM_BASE, DRAM_LEN)) port = 4;
      if (in_window(a, APB_BASE, APB_LEN)) port = APB_PORT;
      if (port < 0) begin
         resp  = RESP_DECERR;
         rdata = '0;
      end else if (port == APB_PORT) begin
         word  = a[31:0] ^ 32'h5a5a_5a5a;
         resp  = err ? RESP_SLVERR : RESP_OKAY;
         rdata = wr ? '0 : (a[2] ? {word, 32'h0} : {32'h0, word});
      end else begin
         resp  = err ? RESP_SLVERR : RESP_OKAY;
         rdata = wr ? '0 : a ^ (64'h1111_1111_1111_1111 * 64'(port));
      end
   endfunction

   // Bytes without a strobe go out as zero
   function automatic apb_data_t apb_wdata(input addr_t a, input data_t wd, input strb_t st);
      apb_data_t half;
      logic [3:0] lanes;
      half  = a[2] ? wd[63:32] : wd[31:0];
      lanes = a[2] ? st[7:4] : st[3:0];
      for (int i = 0; i < 4; i++) begin
         if (!lanes[i]) begin
            half[8*i +: 8] = 8'h00;
         end
      end
      return half;
   endfunction

   // --------------------------------------------------
   // Checks and reporting
   task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
      n_checks++;
      if (got !== exp) begin
         n_errors++;
         $display("ERR %s got %h expected %h", name, got, exp);
      end
   endtask

   task automatic give_up(input string why);
      $display("timeout: %s", why);
      $display("TESTS FAILED");
      $finish;
   endtask

   task automatic end_test(input string name);
      if (n_errors == test_err_start) begin
         $display("test %s: ok", name);
      end else begin
         $display("test %s: %0d errors", name, n_errors - test_err_start);
      end
      test_err_start = n_errors;
   endtask

   // --------------------------------------------------
   // Slave models
   always @(posedge clk) begin
      for (int p = 0; p < NUM_MEM_PORTS; p++) begin
         mem_rsp_valid_i[p] <= 1'b0;
         if (mem_req_valid_o[p] && mem_req_ready_i[p]) begin
            mem_rsp_valid_i[p] <= 1'b1;
            mem_rsp_rdata_i[p] <= mem_addr_o ^ (64'h1111_1111_1111_1111 * 64'(p));
            mem_rsp_err_i[p]   <= (mem_addr_o[11:4] == 8'hff);
         end
         mem_req_ready_i[p] <= stall ? rand_bit() : 1'b1;
      end
   end

   always @(posedge clk) begin
      pready_i    <= stall ? rand_bit() : 1'b1;
      prdata_i    <= paddr_o ^ 32'h5a5a_5a5a;
      pslverr_i   <= (paddr_o[11:4] == 8'hff);
      rsp_ready_i <= stall ? rand_bit() : 1'b1;
   end

   // --------------------------------------------------
   // Monitors
   always @(posedge clk) begin : watch_fwd
      logic [NUM_MEM_PORTS-1:0] exp_vec;
      exp_vec = '0;
      if (cur_port >= 0 && cur_port < NUM_MEM_PORTS) begin
         exp_vec[cur_port] = 1'b1;
      end
      if (rst_n_i) begin
         if (mem_req_valid_o != '0) begin
            check_val("mem_req_valid_o", mem_req_valid_o, exp_vec);
         end
         if (psel_o && cur_port != APB_PORT) begin
            check_val("psel_o", psel_o, 1'b0);
         end
         // Access phase follows setup by one cycle
         if (was_setup) begin
            check_val("penable_o", penable_o, 1'b1);
         end
         was_setup = psel_o && !penable_o;
         if (|(mem_req_valid_o & mem_req_ready_i)) begin
            check_val("mem_addr_o", mem_addr_o, cur_addr);
            check_val("mem_write_o", mem_write_o, cur_write);
            if (cur_write) begin
               check_val("mem_wdata_o", mem_wdata_o, cur_wdata);
               check_val("mem_strb_o", mem_strb_o, cur_strb);
            end
         end
         if (psel_o && penable_o && pready_i) begin
            check_val("paddr_o", paddr_o, cur_addr[31:0]);
            check_val("pwrite_o", pwrite_o, cur_write);
            if (cur_write) begin
               check_val("pwdata_o", pwdata_o, apb_wdata(cur_addr, cur_wdata, cur_strb));
            end
         end
      end
   end

   always @(posedge clk) begin : compare_rsp
      data_t exp_d;
      resp_t exp_r;
      if (rst_n_i && rsp_valid_o && rsp_ready_i) begin
         if (exp_rdata_q.size() == 0) begin
            n_errors++;
            $display("response arrived with no request outstanding");
         end else begin
            exp_d = exp_rdata_q.pop_front();
            exp_r = exp_resp_q.pop_front();
            check_val("rsp_rdata_o", rsp_rdata_o, exp_d);
            check_val("rsp_resp_o", rsp_resp_o, exp_r);
         end
         rsp_count <= rsp_count + 1;
      end
   end

   // --------------------------------------------------
   // Stimulus
   task automatic do_request(input logic wr, input addr_t a, input data_t wd, input strb_t st);
      int    port;
      resp_t resp;
      data_t rdata;
      int    cnt;
      int    done_before;
      ref_model(a, wr, port, resp, rdata);
      exp_rdata_q.push_back(rdata);
      exp_resp_q.push_back(resp);
      cur_port    = port;
      cur_addr    = a;
      cur_write   = wr;
      cur_wdata   = wd;
      cur_strb    = st;
      done_before = rsp_count;
      @(posedge clk);
      req_valid_i <= 1'b1;
      req_write_i <= wr;
      req_addr_i  <= a;
      req_wdata_i <= wd;
      req_strb_i  <= st;
      cnt = 0;
      do begin
         @(posedge clk);
         cnt++;
      end while (!req_ready_o && cnt < LIMIT);
      if (!req_ready_o) give_up("request was never accepted");
      req_valid_i <= 1'b0;
      cnt = 0;
      while (rsp_count == done_before && cnt < LIMIT) begin
         @(posedge clk);
         cnt++;
      end
      if (rsp_count == done_before) give_up("no response for an accepted request");
   endtask

   function automatic addr_t pick_addr(input int sel, input logic [31:0] offs);
      case (sel)
         0:       return ROM_BASE + offs;
         1:       return APB_BASE + offs;
         2:       return CLINT_BASE + offs;
         3:       return SLM_BASE + offs;
         4:       return SLMDDR_BASE + offs;
         5:       return DRAM_BASE + offs;
         default: return 64'h0000_0000_3000_0000 + offs;
      endcase
   endfunction

   initial begin
      int sel;
      rst_n_i         = 1'b0;
      req_valid_i     = 1'b0;
      req_write_i     = 1'b0;
      req_addr_i      = '0;
      req_wdata_i     = '0;
      req_strb_i      = '0;
      rsp_ready_i     = 1'b0;
      mem_req_ready_i = '0;
      mem_rsp_valid_i = '0;
      mem_rsp_rdata_i = '0;
      mem_rsp_err_i   = '0;
      prdata_i        = '0;
      pready_i        = 1'b0;
      pslverr_i       = 1'b0;
      repeat (8) @(posedge clk);
      rst_n_i <= 1'b1;
      @(posedge clk);
      check_val("req_ready_o", req_ready_o, 1'b1);
      check_val("rsp_valid_o", rsp_valid_o, 1'b0);
      check_val("mem_req_valid_o", mem_req_valid_o, '0);
      check_val("psel_o", psel_o, 1'b0);
      check_val("penable_o", penable_o, 1'b0);

      for (int s = 0; s < 6; s++) begin
         if (s != 1) begin
            do_request(1'b0, pick_addr(s, 32'h0000_0128 + 32'(s * 8)), '0, '0);
         end
      end
      end_test("1 memory reads");

      for (int s = 0; s < 6; s++) begin
         if (s != 1) begin
            do_request(1'b1, pick_addr(s, 32'h0000_0340), {rand_bits(32), rand_bits(32)},
                       strb_t'(rand_bits(8)));
         end
      end
      end_test("2 memory writes");

      do_request(1'b0, APB_BASE + 64'h104, '0, '0);
      do_request(1'b0, APB_BASE + 64'h100, '0, '0);
      do_request(1'b1, APB_BASE + 64'h24, 64'h1234_5678_9abc_def0, 8'hff);
      do_request(1'b1, APB_BASE + 64'h20, 64'h0fed_cba9_8765_4321, 8'h0f);
      end_test("3 apb halves");

      do_request(1'b0, 64'h0000_0000_0000_1000, '0, '0);
      do_request(1'b1, 64'h0000_0000_3000_0008, 64'hdead_beef, 8'hff);
      do_request(1'b0, 64'h0000_0001_0000_0000, '0, '0);
      end_test("4 decode error");

      do_request(1'b0, DRAM_BASE + 64'hff0, '0, '0);
      do_request(1'b1, CLINT_BASE + 64'hff8, 64'h55, 8'h01);
      do_request(1'b0, APB_BASE + 64'hff4, '0, '0);
      end_test("5 slave error");

      stall = 1'b1;
      for (int i = 0; i < 40; i++) begin
         sel = rand_bits(3) % 7;
         do_request(rand_bit(), pick_addr(sel, rand_bits(12) & 32'hffc),
                    {rand_bits(32), rand_bits(32)}, strb_t'(rand_bits(8)));
      end
      stall = 1'b0;
      end_test("6 random stalls");

      $display("checks %0d, errors %0d", n_checks, n_errors);
      if (n_errors == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

// ==== verilog.f ====
soc_pkg.sv
addr_decode.sv
req_router.sv
apb_bridge.sv
soc_fabric_top.sv
tb_soc_fabric.sv
